/* logic/mouse_io_pkg.sv */
/* Shared opcodes, decoder states and default constants for the mouse_io controller.
   Modules pull these in with a wildcard import in their header. */

package mouse_io_pkg;

    //////////////////////////////
    // Command protocol
    //////////////////////////////

    // Host opcodes, ASCII letters for easy terminal use
    typedef enum logic [7:0] {
        OP_SET_OUT  = 8'h4F,  // 'O', data byte follows
        OP_SET_EN   = 8'h45,  // 'E', data byte follows
        OP_READ_IN  = 8'h49,  // 'I', replies with pad levels
        OP_READ_CHG = 8'h43   // 'C', replies with change flags and clears them
    } gpio_op_t;

    // Decoder waits for an opcode or for its data byte
    typedef enum logic {
        ST_OPCODE,
        ST_DATA
    } cmd_state_t;

    //////////////////////////////
    // Defaults
    //////////////////////////////

    // Orange LEDs on the board
    localparam int GPIO_DAT_DEFAULT = 6;
    // 27 MHz / 115200 baud
    localparam int BAUD_DIV_DEFAULT = 234;

endpackage: mouse_io_pkg

/* logic/uart_rx.sv */
/* UART receiver, 8N1, sampling each bit once at its middle.
   Pulses rx_strobe for one cycle with the byte on rx_data. */
`timescale 1ns/1ns

module uart_rx
    import mouse_io_pkg::*;
#(
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT
)(
    input  logic       XTAL_IN,
    input  logic       reset,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);

    localparam int CNT_W = $clog2(BAUD_DIV);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    // [0] and [1] synchronizer, [2] previous synchronized level
    logic [2:0]       rxd_r;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_end;

    // Sample point reached in the current bit
    assign bit_end = (cnt == '0);

    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
        begin
            rxd_r     <= 3'b111;
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end
        else
        begin
            rxd_r     <= {rxd_r[1:0], rxd};
            rx_strobe <= 1'b0;
            if (state != RX_IDLE && !bit_end)
            begin
                cnt <= cnt - 1'b1;
            end
            else
            begin
                case (state)
                    RX_IDLE:
                    begin
                        // Falling edge starts a frame, wait half a bit
                        if (rxd_r[2] && !rxd_r[1])
                        begin
                            cnt   <= CNT_W'(BAUD_DIV / 2 - 1);
                            state <= RX_START;
                        end
                    end
                    RX_START:
                    begin
                        // Glitch shorter than half a bit is dropped
                        cnt     <= CNT_W'(BAUD_DIV - 1);
                        bit_idx <= '0;
                        state   <= rxd_r[1] ? RX_IDLE : RX_DATA;
                    end
                    RX_DATA:
                    begin
                        cnt     <= CNT_W'(BAUD_DIV - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= RX_STOP;
                        end
                    end
                    default:
                    begin
                        // Bad stop bit, no strobe
                        rx_strobe <= rxd_r[1];
                        state     <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // Data path, LSB first
    always_ff @(posedge XTAL_IN)
    begin
        if (state == RX_DATA && bit_end)
        begin
            shift <= {rxd_r[1], shift[7:1]};
        end
        if (state == RX_STOP && bit_end && rxd_r[1])
        begin
            rx_data <= shift;
        end
    end

endmodule: uart_rx

/* logic/uart_tx.sv */
/* UART transmitter, 8N1, one frame per tx_start pulse.
   tx_busy covers the whole frame, txd is registered and idles high. */
`timescale 1ns/1ns

module uart_tx
    import mouse_io_pkg::*;
#(
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT
)(
    input  logic       XTAL_IN,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);

    localparam int CNT_W = $clog2(BAUD_DIV);

    logic [CNT_W-1:0] cnt;
    // Frame after the start bit: stop bit on top, data LSB first
    logic [8:0]       frame;
    logic [3:0]       bits_left;

    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
        begin
            txd       <= 1'b1;
            tx_busy   <= 1'b0;
            cnt       <= '0;
            bits_left <= '0;
        end
        else if (!tx_busy)
        begin
            if (tx_start)
            begin
                // Start bit goes out on the next cycle
                txd       <= 1'b0;
                tx_busy   <= 1'b1;
                cnt       <= CNT_W'(BAUD_DIV - 1);
                bits_left <= 4'd9;
            end
        end
        else if (cnt != '0)
        begin
            cnt <= cnt - 1'b1;
        end
        else if (bits_left == '0)
        begin
            // Stop bit done, line already high
            tx_busy <= 1'b0;
        end
        else
        begin
            txd       <= frame[0];
            cnt       <= CNT_W'(BAUD_DIV - 1);
            bits_left <= bits_left - 1'b1;
        end
    end

    // Shift register, filled with ones behind the data
    always_ff @(posedge XTAL_IN)
    begin
        if (!tx_busy && tx_start)
        begin
            frame <= {1'b1, tx_data};
        end
        else if (tx_busy && cnt == '0 && bits_left != '0)
        begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule: uart_tx

/* logic/gpio_cmd.sv */
/* Two-byte command decoder between the UART and the GPIO pin cells.
   Owns the output and enable registers and holds one pending reply byte. */
`timescale 1ns/1ns

module gpio_cmd
    import mouse_io_pkg::*;
#(
    parameter int GPIO_DAT = GPIO_DAT_DEFAULT
)(
    input  logic                XTAL_IN,
    input  logic                reset,
    // UART receive side
    input  logic [7:0]          rx_data,
    input  logic                rx_strobe,
    // UART transmit side
    output logic [7:0]          tx_data,
    output logic                tx_start,
    input  logic                tx_busy,
    // Pin cells
    output logic [GPIO_DAT-1:0] out,
    output logic [GPIO_DAT-1:0] en,
    input  logic [GPIO_DAT-1:0] pin_in,
    input  logic [GPIO_DAT-1:0] chg,
    output logic                chg_clear
);

    cmd_state_t state;
    // Opcode waiting for its data byte
    gpio_op_t   op_q;

    // Single reply slot, host waits for each reply
    logic       pend_valid;
    logic [7:0] pend_data;

    logic opcode_strobe;
    logic read_in;
    logic read_chg;

    //////////////////////////////
    // Opcode decode
    //////////////////////////////

    assign opcode_strobe = rx_strobe && (state == ST_OPCODE);
    assign read_in       = opcode_strobe && (rx_data == OP_READ_IN);
    assign read_chg      = opcode_strobe && (rx_data == OP_READ_CHG);

    // Flags clear on the same edge the reply is captured
    assign chg_clear = read_chg;

    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
        begin
            state <= ST_OPCODE;
            out   <= '0;
            en    <= '0;
        end
        else if (rx_strobe)
        begin
            if (state == ST_OPCODE)
            begin
                // Unknown opcodes fall through, decoder stays put
                if (rx_data == OP_SET_OUT || rx_data == OP_SET_EN)
                begin
                    state <= ST_DATA;
                end
            end
            else
            begin
                // Upper data bits ignored
                if (op_q == OP_SET_OUT)
                    out <= rx_data[GPIO_DAT-1:0];
                else
                    en  <= rx_data[GPIO_DAT-1:0];
                state <= ST_OPCODE;
            end
        end
    end

    always_ff @(posedge XTAL_IN)
    begin
        if (opcode_strobe)
        begin
            op_q <= gpio_op_t'(rx_data);
        end
    end

    //////////////////////////////
    // Reply slot
    //////////////////////////////

    // New capture wins over release in the same cycle
    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
            pend_valid <= 1'b0;
        else if (read_in || read_chg)
            pend_valid <= 1'b1;
        else if (tx_start)
            pend_valid <= 1'b0;
    end

    // Replies zero-extended to a byte
    always_ff @(posedge XTAL_IN)
    begin
        if (read_in)
            pend_data <= 8'(pin_in);
        else if (read_chg)
            pend_data <= 8'(chg);
    end

    // Released on the first idle cycle of the transmitter
    assign tx_start = pend_valid && !tx_busy;
    assign tx_data  = pend_data;

endmodule: gpio_cmd

/* logic/gpio_pin.sv */
/* One bidirectional GPIO pad with active-low drive and input resync.
   Keeps a sticky flag of level changes until chg_clear. */
`timescale 1ns/1ns

module gpio_pin (
    input  logic XTAL_IN,
    input  logic reset,
    input  logic out,
    input  logic en,
    inout  logic pad,
    output logic pin_in,
    output logic chg,
    input  logic chg_clear
);

    logic out_q;
    logic en_q;
    // Resync stages and previous synchronized level
    logic pad_r0;
    logic pad_r1;
    logic pad_prev;

    // Output register, pad floats after reset
    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
        begin
            out_q <= 1'b0;
            en_q  <= 1'b0;
        end
        else
        begin
            out_q <= out;
            en_q  <= en;
        end
    end

    // LEDs light on a low pad
    assign pad = en_q ? ~out_q : 1'bz;

    always_ff @(posedge XTAL_IN)
    begin
        if (reset)
        begin
            // LED off level
            pad_r0   <= 1'b1;
            pad_r1   <= 1'b1;
            pad_prev <= 1'b1;
            chg      <= 1'b0;
        end
        else
        begin
            pad_r0   <= pad;
            pad_r1   <= pad_r0;
            pad_prev <= pad_r1;
            // Set beats clear
            chg      <= (pad_r1 ^ pad_prev) | (chg & ~chg_clear);
        end
    end

    assign pin_in = pad_r1;

endmodule: gpio_pin

/* logic/mouse_io_tangnano9k.sv */
/* Tang Nano 9k board top: UART host interface driving the orange LED pads as GPIO.
   Button S1 resets, XTAL_IN clocks everything directly. */
`timescale 1ns/1ns

module mouse_io_tangnano9k
    import mouse_io_pkg::*;
#(
    parameter int GPIO_DAT = GPIO_DAT_DEFAULT,
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT
)(
    // 27 MHz crystal
    input  logic       XTAL_IN,
    // Buttons, active low
    input  logic [2:1] S,
    // Orange LEDs, active low
    inout  logic [6:1] LED,
    // UART
    output logic       FPGA_TX,
    input  logic       FPGA_RX
);

    logic                reset;
    logic                btn_r0;
    logic                btn_r1;

    logic [7:0]          rx_data;
    logic                rx_strobe;
    logic [7:0]          tx_data;
    logic                tx_start;
    logic                tx_busy;

    logic [GPIO_DAT-1:0] gpio_out;
    logic [GPIO_DAT-1:0] gpio_en;
    logic [GPIO_DAT-1:0] pin_in;
    logic [GPIO_DAT-1:0] chg;
    logic                chg_clear;

    //////////////////////////////
    // Reset synchronizer
    //////////////////////////////

    // No debouncing, S[2] unused
    always_ff @(posedge XTAL_IN)
    begin
        btn_r0 <= S[1];
        btn_r1 <= btn_r0;
    end

    assign reset = ~btn_r1;

    //////////////////////////////
    // UART and command decoder
    //////////////////////////////

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
        .XTAL_IN   (XTAL_IN),
        .reset     (reset),
        .rxd       (FPGA_RX),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    gpio_cmd #(.GPIO_DAT(GPIO_DAT)) u_cmd (
        .XTAL_IN   (XTAL_IN),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .out       (gpio_out),
        .en        (gpio_en),
        .pin_in    (pin_in),
        .chg       (chg),
        .chg_clear (chg_clear)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
        .XTAL_IN  (XTAL_IN),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (FPGA_TX),
        .tx_busy  (tx_busy)
    );

    //////////////////////////////
    // Pin cells
    //////////////////////////////

    // LED numbering starts at 1
    for (genvar i = 0; i < GPIO_DAT; i++)
    begin : g_pin
        gpio_pin u_pin (
            .XTAL_IN   (XTAL_IN),
            .reset     (reset),
            .out       (gpio_out[i]),
            .en        (gpio_en[i]),
            .pad       (LED[i+1]),
            .pin_in    (pin_in[i]),
            .chg       (chg[i]),
            .chg_clear (chg_clear)
        );
    end

endmodule: mouse_io_tangnano9k

/* bench/mouse_io_assert.sv */
/* Concurrent checks bound into the board top from the bench.
   Covers the idle UART line, receive strobe width and enables after reset. */
`timescale 1ns/1ns

module mouse_io_assert
    import mouse_io_pkg::*;
#(
    parameter int GPIO_DAT = GPIO_DAT_DEFAULT
)(
    input logic                XTAL_IN,
    input logic                reset,
    input logic                txd,
    input logic                tx_busy,
    input logic                rx_strobe,
    input logic [GPIO_DAT-1:0] en
);

    // Failed assertion count
    int failures = 0;

    //////////////////////////////
    // UART
    //////////////////////////////

    // Line idles high between frames
    property txd_idle_high;
        @(posedge XTAL_IN) disable iff (reset !== 1'b0)
        !tx_busy |-> txd;
    endproperty

    // One strobe per received byte
    property rx_strobe_single;
        @(posedge XTAL_IN) disable iff (reset !== 1'b0)
        rx_strobe |=> !rx_strobe;
    endproperty

    //////////////////////////////
    // GPIO
    //////////////////////////////

    // Pads float once reset has been seen
    property en_clear_after_reset;
        @(posedge XTAL_IN)
        reset |=> (en == '0);
    endproperty

    a_txd_idle: assert property (txd_idle_high)
    else
    begin
        $error("txd low while the transmitter is idle");
        failures++;
    end

    a_rx_strobe: assert property (rx_strobe_single)
    else
    begin
        $error("rx_strobe high for two cycles");
        failures++;
    end

    a_en_reset: assert property (en_clear_after_reset)
    else
    begin
        $error("enable register not cleared by reset");
        failures++;
    end

endmodule: mouse_io_assert

bind mouse_io_tangnano9k mouse_io_assert #(.GPIO_DAT(GPIO_DAT)) u_assert (
    .XTAL_IN   (XTAL_IN),
    .reset     (reset),
    .txd       (FPGA_TX),
    .tx_busy   (tx_busy),
    .rx_strobe (rx_strobe),
    .en        (gpio_en)
);

/* bench/mouse_io_tb.sv */
/* Directed testbench for the board top: a UART host model sends commands,
   bench drivers and pullups sit on the LED pads, and replies are checked. */
`timescale 1ns/1ns

module mouse_io_tb
    import mouse_io_pkg::*;
;

    localparam int BAUD_DIV = 8;
    localparam int PINS = GPIO_DAT_DEFAULT;
    // Start bit of a reply shows up within a bit time or so
    localparam int REPLY_WAIT = 3 * BAUD_DIV;
    // About 60 frames of 80 cycles plus settling gaps, with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic            XTAL_IN;
    logic [2:1]      S;
    wire  [6:1]      led;
    logic            FPGA_TX;
    logic            FPGA_RX;

    // Bench pad drivers
    logic [PINS-1:0] ext_drv;
    logic [PINS-1:0] ext_val;
    // Shadow of the DUT registers
    logic [PINS-1:0] en_sh;
    logic [PINS-1:0] out_sh;

    logic [31:0]     rng;
    int              cycles;
    int              tx_low_cycles;
    int              errors;
    int              tests_passed;
    int              tests_failed;

    mouse_io_tangnano9k #(.GPIO_DAT(PINS), .BAUD_DIV(BAUD_DIV)) uut (
        .XTAL_IN (XTAL_IN),
        .S       (S),
        .LED     (led),
        .FPGA_TX (FPGA_TX),
        .FPGA_RX (FPGA_RX)
    );

    // External level or high impedance, weak pullup behind it
    for (genvar i = 0; i < PINS; i++)
    begin : g_pad
        assign led[i+1] = ext_drv[i] ? ext_val[i] : 1'bz;
        pullup (led[i+1]);
    end

    initial
    begin
        XTAL_IN = 1'b0;
        forever #4 XTAL_IN = ~XTAL_IN;
    end

    //////////////////////////////
    // Timeout and line monitor
    //////////////////////////////

    always @(posedge XTAL_IN)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Any low cycle on FPGA_TX is part of a reply frame
    always @(negedge XTAL_IN)
    begin
        if (FPGA_TX === 1'b0)
            tx_low_cycles <= tx_low_cycles + 1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Enabled pins show the inverted output, others the bench or the pullup
    function automatic logic [PINS-1:0] expected_pads(input logic [PINS-1:0] en_v,
                                                      input logic [PINS-1:0] out_v,
                                                      input logic [PINS-1:0] drv_v,
                                                      input logic [PINS-1:0] val_v);
        return (en_v & ~out_v) | (~en_v & ~drv_v) | (~en_v & drv_v & val_v);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Error: %s expected %0h got %0h", name, exp, got);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors)
        begin
            $display("Test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display("Test %s: %0d error(s)", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    // Host to DUT, 8N1, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            FPGA_RX = frame[i];
            repeat (BAUD_DIV) @(negedge XTAL_IN);
        end
    endtask

    // DUT to host, sampled mid-bit
    task automatic receive_byte(output logic [7:0] b);
        int wait_cycles;
        wait_cycles = 0;
        b = 8'h00;
        while (FPGA_TX !== 1'b0 && wait_cycles < REPLY_WAIT)
        begin
            @(negedge XTAL_IN);
            wait_cycles++;
        end
        if (FPGA_TX !== 1'b0)
        begin
            $display("No reply started on FPGA_TX within %0d cycles", REPLY_WAIT);
            errors++;
        end
        else
        begin
            repeat (BAUD_DIV / 2) @(negedge XTAL_IN);
            for (int i = 0; i < 8; i++)
            begin
                repeat (BAUD_DIV) @(negedge XTAL_IN);
                b[i] = FPGA_TX;
            end
            repeat (BAUD_DIV) @(negedge XTAL_IN);
            if (FPGA_TX !== 1'b1)
            begin
                $display("Reply on FPGA_TX has no stop bit");
                errors++;
            end
            // Rest of the stop bit
            repeat (BAUD_DIV / 2) @(negedge XTAL_IN);
        end
    endtask

    // Register write, then wait for the pad cell to follow
    task automatic write_reg(input gpio_op_t op, input logic [7:0] data);
        send_byte(op);
        send_byte(data);
        if (op == OP_SET_EN)
            en_sh = data[PINS-1:0];
        else
            out_sh = data[PINS-1:0];
        repeat (4) @(negedge XTAL_IN);
    endtask

    task automatic read_reg(input gpio_op_t op, output logic [7:0] b);
        send_byte(op);
        receive_byte(b);
    endtask

    task automatic check_pads(input string name);
        logic [PINS-1:0] exp;
        exp = expected_pads(en_sh, out_sh, ext_drv, ext_val);
        if (led[PINS:1] !== exp)
            report_mismatch(name, exp, led[PINS:1]);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        int start_errors;
        logic [7:0] b;
        start_errors = errors;
        if (FPGA_TX !== 1'b1)
            report_mismatch("FPGA_TX", 1, FPGA_TX);
        if (led[PINS:1] !== '1)
            report_mismatch("LED", 8'h3F, led[PINS:1]);
        read_reg(OP_READ_IN, b);
        if (b !== 8'h3F)
            report_mismatch("FPGA_TX reply", 8'h3F, b);
        finish_test("reset_state", start_errors);
    endtask

    task automatic test_drive();
        int start_errors;
        start_errors = errors;
        // Bench owns pins 0 and 1, DUT the rest
        ext_drv = 6'b000011;
        ext_val = 6'b000001;
        write_reg(OP_SET_EN, 8'hFC);
        check_pads("LED after enable");
        // Upper data bits must be ignored
        write_reg(OP_SET_OUT, 8'hEA);
        check_pads("LED after output");
        finish_test("drive", start_errors);
    endtask

    task automatic test_input_readback();
        int start_errors;
        logic [7:0] b;
        start_errors = errors;
        write_reg(OP_SET_EN, 8'h00);
        ext_drv = '1;
        ext_val = 6'b100101;
        repeat (4) @(negedge XTAL_IN);
        read_reg(OP_READ_IN, b);
        if (b !== {2'b00, ext_val})
            report_mismatch("FPGA_TX reply", {2'b00, ext_val}, b);
        // Release upper pins before the DUT takes them
        ext_drv = 6'b000111;
        write_reg(OP_SET_OUT, 8'h10);
        write_reg(OP_SET_EN, 8'h38);
        check_pads("LED mixed");
        read_reg(OP_READ_IN, b);
        if (b !== {2'b00, expected_pads(en_sh, out_sh, ext_drv, ext_val)})
            report_mismatch("FPGA_TX reply", expected_pads(en_sh, out_sh, ext_drv, ext_val), b);
        finish_test("input_readback", start_errors);
    endtask

    task automatic test_change_flags();
        int start_errors;
        logic [7:0] b;
        start_errors = errors;
        // Flush whatever earlier tests left behind
        read_reg(OP_READ_CHG, b);
        ext_val = ext_val ^ 6'b000101;
        repeat (6) @(negedge XTAL_IN);
        read_reg(OP_READ_CHG, b);
        if (b !== 8'h05)
            report_mismatch("FPGA_TX reply", 8'h05, b);
        read_reg(OP_READ_CHG, b);
        if (b !== 8'h00)
            report_mismatch("FPGA_TX reply", 8'h00, b);
        finish_test("change_flags", start_errors);
    endtask

    task automatic test_random();
        int start_errors;
        int low_before;
        start_errors = errors;
        low_before = tx_low_cycles;
        // Unknown opcode, decoder must stay ready for the next one
        send_byte(8'h5A);
        for (int n = 0; n < 10; n++)
        begin
            rng = xorshift32(rng);
            // Bench drives only pins the DUT owns neither before nor after
            ext_drv = ~(en_sh | rng[PINS-1:0]) & rng[16 +: PINS];
            ext_val = rng[24 +: PINS];
            write_reg(OP_SET_EN, rng[7:0]);
            write_reg(OP_SET_OUT, rng[15:8]);
            check_pads("LED random");
        end
        if (tx_low_cycles != low_before)
            report_mismatch("FPGA_TX low cycles", 0, tx_low_cycles - low_before);
        finish_test("random", start_errors);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        S             = 2'b10;
        FPGA_RX       = 1'b1;
        ext_drv       = '0;
        ext_val       = '0;
        en_sh         = '0;
        out_sh        = '0;
        rng           = 32'h7021;
        cycles        = 0;
        tx_low_cycles = 0;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        // S[1] low for two clock edges
        repeat (2) @(posedge XTAL_IN);
        @(negedge XTAL_IN);
        S[1] = 1'b1;
        repeat (4) @(negedge XTAL_IN);

        test_reset_state();
        test_drive();
        test_input_readback();
        test_change_flags();
        test_random();

        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, uut.u_assert.failures);
        if (tests_failed == 0 && errors == 0 && uut.u_assert.failures == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule: mouse_io_tb

/* mouse_io.f */
logic/mouse_io_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/gpio_cmd.sv
logic/gpio_pin.sv
logic/mouse_io_tangnano9k.sv
bench/mouse_io_assert.sv
bench/mouse_io_tb.sv

/* Bender.yml */
package:
  name: mouse_io

sources:
  - files:
      - logic/mouse_io_pkg.sv
      - logic/uart_rx.sv
      - logic/uart_tx.sv
      - logic/gpio_cmd.sv
      - logic/gpio_pin.sv
      - logic/mouse_io_tangnano9k.sv
  - target: test
    files:
      - bench/mouse_io_assert.sv
      - bench/mouse_io_tb.sv
